// ==== testbench/trace.txt ====
# records: I word = input-port load, X word = instruction, E word = expected outPortData,
# B word word = instruction plus a second start while busy; several records may share a line
X 6B800000 E 00000000  # out r7 after reset
I 12345678 X 60800000  # in r1
I 9ABCDEF0 X 61000000  # in r2
X 68800000 E 12345678  # out r1
X 69000000 E 9ABCDEF0  # out r2
X 01890000 X 69800000 E ACF13568  # add r3, r1, r2
X 0A090000 X 6A000000 E 77777788  # sub r4, r1, r2
X 02910000 X 6A800000 E 3579BDE0  # add r5, r2, r2 wraps
X 13090000 X 6B000000 E 12345670  # and r6, r1, r2
X 1B890000 X 6B800000 E 9ABCDEF8  # or r7, r1, r2
X 34080000 X 6C000000 E EDCBA988  # neg r8, r1
X 3C900000 X 6C800000 E 6543210F  # not r9, r2
I DEADBEEF X 60000000  # in r0, ignored as a base
X 68000000 E DEADBEEF  # out r0 reads the stored word
X 45012345 X 6D000000 E 00012345  # addi r10, r0, 0x12345
X 45840000 X 6D800000 E FFFC0000  # addi r11, r0, most negative
X 460FFFF8 X 6E000000 E 12345670  # addi r12, r1, -8
X 46900100 X 6E800000 E 9ABCDFF0  # addi r13, r2, 0x100
X 41800000 X 42000001 X 4280001F  # shift amounts r3 = 0, r4 = 1, r5 = 31
X 23118000 X 6B000000 E 9ABCDEF0  # shl r6, r2, r3
X 23120000 X 6B000000 E 3579BDE0  # shl r6, r2, r4
X 234A8000 X 6B000000 E 80000000  # shl r6, r9, r5
X 2B918000 X 6B800000 E 9ABCDEF0  # shr r7, r2, r3
X 2B920000 X 6B800000 E 4D5E6F78  # shr r7, r2, r4
X 2B928000 X 6B800000 E 00000001  # shr r7, r2, r5
X 4707FFFD I 7FFFFFFF X 67800000  # r14 = -3, r15 = 0x7fffffff
X 48778000  # mul r14, r15
X 51800000 X 69800000 E FFFFFFFE  # mfhi r3
X 5A000000 X 6A000000 E 80000003  # mflo r4
X 487F8000  # mul r15, r15
X 51800000 X 69800000 E 3FFFFFFF  # mfhi r3
X 5A000000 X 6A000000 E 00000001  # mflo r4
B 02890000 42800077  # add r5, r1, r2, addi r5 sent while busy
X 6A800000 E ACF13568  # out r5 keeps the add result

// ==== tb.f ====
common/cpuPkg.sv
hw/datapath/regFile.sv
hw/datapath/busMux.sv
hw/datapath/alu.sv
hw/datapath/datapath.sv
hw/controlUnit.sv
hw/miniCpu.sv
testbench/cpu_props.sv
testbench/tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb.sv ====
module tb import cpuPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClockPeriod = 10;
  localparam int ResetCycles = 4;
  localparam int Seed = 88981;
  localparam string TraceFile = "testbench/trace.txt";

  logic clock = 1'b0;
  logic rst;
  logic start;
  word_t instr;
  word_t inPortData;
  logic inPortStrobe;
  word_t outPortData;
  logic busy;
  logic done;

  logic [7:0] kinds[$];
  word_t firstWords[$];
  word_t secondWords[$];
  int watchdogCycles = 0;

  miniCpu u_dut (
    .clock(clock),
    .rst(rst),
    .start(start),
    .instr(instr),
    .inPortData(inPortData),
    .inPortStrobe(inPortStrobe),
    .outPortData(outPortData),
    .busy(busy),
    .done(done)
  );

  bind controlUnit cpu_props u_props (
    .clock(clock),
    .rst(rst),
    .ctrl(ctrl),
    .busy(busy),
    .done(done)
  );

  always #(ClockPeriod / 2) clock = ~clock;

  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic checkWord(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      reportFailure($sformatf("FAILED %s: got 0x%08h expected 0x%08h", name, got, expected));
    end
  endtask

  task automatic checkLevel(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      reportFailure($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, expected));
    end
  endtask

  task automatic loadInPort(input word_t word);
    @(posedge clock);
    inPortData <= word;
    inPortStrobe <= 1'b1;
    @(posedge clock);
    inPortStrobe <= 1'b0;
  endtask

  // issue one instruction, optionally a second start while busy, wait for done
  task automatic runInstr(input word_t word, input logic extraStart, input word_t extraWord);
    @(posedge clock);
    start <= 1'b1;
    instr <= word;
    @(posedge clock);
    start <= extraStart;   // second start sampled in step 1
    if (extraStart) instr <= extraWord;
    @(negedge clock);
    checkLevel("busy", busy, 1'b1);
    checkLevel("done", done, 1'b0);
    if (extraStart) begin
      @(posedge clock);
      start <= 1'b0;
      @(negedge clock);
    end
    while (done !== 1'b1) @(negedge clock);   // watchdog bounds this
    checkLevel("busy", busy, 1'b0);
    @(negedge clock);
    checkLevel("done", done, 1'b0);   // single pulse
    checkLevel("busy", busy, 1'b0);
  endtask

  task automatic readTrace();
    int fd;
    int ch;
    logic [7:0] kind;
    word_t first;
    word_t second;
    fd = $fopen(TraceFile, "r");
    if (fd == 0) reportFailure($sformatf("could not open trace file %s", TraceFile));
    while ($fscanf(fd, " %c", kind) == 1) begin
      if (kind == "#") begin
        ch = 0;
        while (ch != 10 && ch != -1) ch = $fgetc(fd);   // skip comment
      end else begin
        first = '0;
        second = '0;
        if ($fscanf(fd, " %h", first) != 1) reportFailure("trace record is missing its word");
        if (kind == "B" && $fscanf(fd, " %h", second) != 1) begin
          reportFailure("trace record B is missing its second word");
        end
        kinds.push_back(kind);
        firstWords.push_back(first);
        secondWords.push_back(second);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    wait (watchdogCycles != 0);
    #(watchdogCycles * ClockPeriod);
    reportFailure("run hung: trace not finished within the cycle budget");
  end

  always @(negedge clock) begin
    if (u_dut.u_controlUnit.u_props.failCount != 0) begin
      reportFailure("a control unit assertion failed");
    end
  end

  initial begin
    rst <= 1'b1;
    start <= 1'b0;
    instr <= '0;
    inPortData <= '0;
    inPortStrobe <= 1'b0;
    void'($urandom(Seed));
    readTrace();
    watchdogCycles = kinds.size() * 10 + 100;

    repeat (ResetCycles) @(posedge clock);
    rst <= 1'b0;
    @(negedge clock);
    checkLevel("busy", busy, 1'b0);
    checkLevel("done", done, 1'b0);
    checkWord("outPortData", outPortData, '0);

    foreach (kinds[i]) begin
      case (kinds[i])
        "I": loadInPort(firstWords[i]);
        "X": runInstr(firstWords[i], 1'b0, '0);
        "B": runInstr(firstWords[i], 1'b1, secondWords[i]);
        "E": begin
          @(negedge clock);
          checkWord("outPortData", outPortData, firstWords[i]);
        end
        default: reportFailure($sformatf("unknown trace record kind %c", kinds[i]));
      endcase
      repeat ($urandom_range(3)) @(posedge clock);   // idle gap
    end

    @(negedge clock);
    if (u_dut.u_controlUnit.u_props.failCount == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      reportFailure("a control unit assertion failed");
    end
  end

endmodule

// ==== testbench/cpu_props.sv ====
module cpu_props import cpuPkg::*; (
  input logic  clock,
  input logic  rst,
  input ctrl_t ctrl,
  input logic  busy,
  input logic  done
);
  timeunit 1ns;
  timeprecision 1ps;

  int failCount = 0;   // polled by the testbench
  logic [21:0] outEnables;

  assign outEnables = {ctrl.inPortOut, ctrl.cOut, ctrl.zLowOut, ctrl.zHighOut,
                       ctrl.loOut, ctrl.hiOut, ctrl.regOut};

  regInOneHot: assert property (@(posedge clock) disable iff (rst) $onehot0(ctrl.regIn))
    else begin
      $error("regIn selects more than one register");
      failCount++;
    end

  busSingleDriver: assert property (@(posedge clock) disable iff (rst) $onehot0(outEnables))
    else begin
      $error("more than one bus output enable set");
      failCount++;
    end

  doneNotBusy: assert property (@(posedge clock) disable iff (rst) !(done && busy))
    else begin
      $error("done and busy high together");
      failCount++;
    end

  idleCtrlZero: assert property (@(posedge clock) disable iff (rst) !busy |-> ctrl == '0)
    else begin
      $error("control word not zero outside the step cycles");
      failCount++;
    end

endmodule

// ==== hw/miniCpu.sv ====
module miniCpu import cpuPkg::*; (
  input  logic  clock,
  input  logic  rst,
  input  logic  start,
  input  word_t instr,
  input  word_t inPortData,
  input  logic  inPortStrobe,
  output word_t outPortData,
  output logic  busy,
  output logic  done
);

  ctrl_t ctrl;
  word_t immValue;

  controlUnit u_controlUnit (
    .clock(clock),
    .rst(rst),
    .start(start),
    .instr(instr),
    .ctrl(ctrl),
    .immValue(immValue),
    .busy(busy),
    .done(done)
  );

  datapath u_datapath (
    .clock(clock),
    .rst(rst),
    .ctrl(ctrl),
    .immValue(immValue),
    .inPortData(inPortData),
    .inPortStrobe(inPortStrobe),
    .outPortData(outPortData)
  );

endmodule

// ==== hw/controlUnit.sv ====
module controlUnit import cpuPkg::*; (
  input  logic  clock,
  input  logic  rst,
  input  logic  start,
  input  word_t instr,
  output ctrl_t ctrl,
  output word_t immValue,
  output logic  busy,
  output logic  done
);

  typedef enum logic [2:0] {
    stIdle,
    stT1,
    stT2,
    stT3,
    stT4,
    stFinish
  } step_t;

  step_t state, stateNext;
  word_t instrQ;
  opcode_t opcode;
  regIdx_t ra, rb, rc;
  regMask_t raMask, rbMask, rcMask;
  logic [2:0] numSteps;
  logic accept, twoSrc, unary;
  aluOp_t aluFn;

  function automatic regMask_t decodeReg(regIdx_t idx);
    return regMask_t'(1) << idx;
  endfunction

  assign opcode = opcode_t'(instrQ[OpMsb:OpLsb]);
  assign ra = instrQ[RaMsb:RaLsb];
  assign rb = instrQ[RbMsb:RbLsb];
  assign rc = instrQ[RcMsb:RcLsb];
  assign raMask = decodeReg(ra);
  assign rbMask = decodeReg(rb);
  assign rcMask = decodeReg(rc);
  assign immValue = {{($bits(word_t) - ImmBits){instrQ[ImmMsb]}}, instrQ[ImmMsb:ImmLsb]};

  assign busy = (state inside {stT1, stT2, stT3, stT4});
  assign done = (state == stFinish);
  assign accept = start && !busy;

  assign twoSrc = (opcode inside {opAdd, opSub, opAnd, opOr, opShl, opShr, opAddi, opMul});
  assign unary = (opcode inside {opNeg, opNot});

  always_comb begin
    case (opcode)
      opAdd, opSub, opAnd, opOr, opShl, opShr, opAddi: numSteps = 3'd3;
      opMul: numSteps = 3'd4;
      opNeg, opNot: numSteps = 3'd2;
      default: numSteps = 3'd1;   // in, out, mfhi, mflo
    endcase
  end

  always_comb begin
    case (opcode)
      opSub: aluFn = aluSub;
      opAnd: aluFn = aluAnd;
      opOr: aluFn = aluOr;
      opShl: aluFn = aluShl;
      opShr: aluFn = aluShr;
      opNeg: aluFn = aluNeg;
      opNot: aluFn = aluNot;
      opMul: aluFn = aluMul;
      default: aluFn = aluAdd;
    endcase
  end

  always_comb begin
    case (state)
      stIdle: stateNext = accept ? stT1 : stIdle;
      stT1: stateNext = (numSteps == 3'd1) ? stFinish : stT2;
      stT2: stateNext = (numSteps == 3'd2) ? stFinish : stT3;
      stT3: stateNext = (numSteps == 3'd3) ? stFinish : stT4;
      stT4: stateNext = stFinish;
      default: stateNext = accept ? stT1 : stIdle; // back-to-back start allowed
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= stIdle;
      instrQ <= '0;
    end else begin
      state <= stateNext;
      if (accept) instrQ <= instr;
    end
  end

  always_comb begin
    ctrl = '0;
    case (state)
      stT1: begin
        case (opcode)
          opNeg, opNot: begin
            ctrl.regOut = rbMask;
            ctrl.zIn = 1'b1;
            ctrl.aluOp = aluFn;
          end
          opIn: begin
            ctrl.inPortOut = 1'b1;
            ctrl.regIn = raMask;
          end
          opOut: begin
            ctrl.regOut = raMask;
            ctrl.outPortEn = 1'b1;
          end
          opMfhi: begin
            ctrl.hiOut = 1'b1;
            ctrl.regIn = raMask;
          end
          opMflo: begin
            ctrl.loOut = 1'b1;
            ctrl.regIn = raMask;
          end
          default: begin
            if (twoSrc) begin
              ctrl.regOut = rbMask;
              ctrl.baOut = (opcode == opAddi); // base read for addi only
              ctrl.yIn = 1'b1;
            end
          end
        endcase
      end
      stT2: begin
        if (twoSrc) begin
          if (opcode == opAddi) ctrl.cOut = 1'b1;
          else ctrl.regOut = rcMask;
          ctrl.zIn = 1'b1;
          ctrl.aluOp = aluFn;
        end else if (unary) begin
          ctrl.zLowOut = 1'b1;
          ctrl.regIn = raMask;
        end
      end
      stT3: begin
        if (twoSrc) begin
          ctrl.zLowOut = 1'b1;
          if (opcode == opMul) ctrl.loIn = 1'b1;
          else ctrl.regIn = raMask;
        end
      end
      stT4: begin
        ctrl.zHighOut = 1'b1;   // mul upper half
        ctrl.hiIn = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/datapath/datapath.sv ====
module datapath import cpuPkg::*; (
  input  logic  clock,
  input  logic  rst,
  input  ctrl_t ctrl,
  input  word_t immValue,
  input  word_t inPortData,
  input  logic  inPortStrobe,
  output word_t outPortData
);

  word_t [NumRegs-1:0] regWords;
  word_t bus;
  word_t yWord, zHighWord, zLowWord, hiWord, loWord, inPortWord;
  dword_t aluResult;

  regFile u_regFile (
    .clock(clock),
    .rst(rst),
    .regIn(ctrl.regIn),
    .baOut(ctrl.baOut),
    .bus(bus),
    .regWords(regWords)
  );

  busMux u_busMux (
    .ctrl(ctrl),
    .regWords(regWords),
    .hiWord(hiWord),
    .loWord(loWord),
    .zHighWord(zHighWord),
    .zLowWord(zLowWord),
    .immValue(immValue),
    .inPortWord(inPortWord),
    .bus(bus)
  );

  alu u_alu (
    .aluOp(ctrl.aluOp),
    .a(yWord),
    .b(bus),
    .result(aluResult)
  );

  always_ff @(posedge clock) begin
    if (rst) begin
      yWord <= '0;
      zHighWord <= '0;
      zLowWord <= '0;
      hiWord <= '0;
      loWord <= '0;
      inPortWord <= '0;
      outPortData <= '0;
    end else begin
      if (ctrl.yIn) yWord <= bus;
      if (ctrl.zIn) begin
        zHighWord <= aluResult[63:32];  // Z takes the ALU, not the bus
        zLowWord <= aluResult[31:0];
      end
      if (ctrl.hiIn) hiWord <= bus;
      if (ctrl.loIn) loWord <= bus;
      if (inPortStrobe) inPortWord <= inPortData;
      if (ctrl.outPortEn) outPortData <= bus;
    end
  end

endmodule

// ==== hw/datapath/alu.sv ====
module alu import cpuPkg::*; (
  input  aluOp_t aluOp,
  input  word_t  a,
  input  word_t  b,
  output dword_t result
);

  logic signed [63:0] product;
  word_t lowWord;
  logic [ShiftBits-1:0] shamt;

  assign shamt = b[ShiftBits-1:0];
  assign product = $signed(a) * $signed(b);

  always_comb begin
    case (aluOp)
      aluSub: lowWord = a - b;
      aluAnd: lowWord = a & b;
      aluOr: lowWord = a | b;
      aluShl: lowWord = a << shamt;
      aluShr: lowWord = a >> shamt;   // logical
      aluNeg: lowWord = -b;
      aluNot: lowWord = ~b;
      default: lowWord = a + b;
    endcase
  end

  always_comb begin
    if (aluOp == aluMul) begin
      result = product;
    end else begin
      result = {32'b0, lowWord};
    end
  end

endmodule

// ==== hw/datapath/busMux.sv ====
module busMux import cpuPkg::*; (
  input  ctrl_t               ctrl,
  input  word_t [NumRegs-1:0] regWords,
  input  word_t               hiWord,
  input  word_t               loWord,
  input  word_t               zHighWord,
  input  word_t               zLowWord,
  input  word_t               immValue,
  input  word_t               inPortWord,
  output word_t               bus
);

  logic [21:0] outEn;
  logic [4:0] srcSel;
  logic anyEn;

  assign outEn = {ctrl.inPortOut, ctrl.cOut, ctrl.zLowOut, ctrl.zHighOut,
                  ctrl.loOut, ctrl.hiOut, ctrl.regOut};

  // one-hot to source number
  always_comb begin
    srcSel = '0;
    anyEn = 1'b0;
    for (int i = 0; i < $bits(outEn); i++) begin
      if (outEn[i]) begin
        srcSel = 5'(i);
        anyEn = 1'b1;
      end
    end
  end

  always_comb begin
    if (!anyEn) begin
      bus = '0;   // nobody drives
    end else begin
      case (srcSel)
        5'd16: bus = hiWord;
        5'd17: bus = loWord;
        5'd18: bus = zHighWord;
        5'd19: bus = zLowWord;
        5'd20: bus = immValue;
        5'd21: bus = inPortWord;
        default: bus = regWords[srcSel[3:0]];
      endcase
    end
  end

endmodule

// ==== hw/datapath/regFile.sv ====
module regFile import cpuPkg::*; (
  input  logic                clock,
  input  logic                rst,
  input  regMask_t            regIn,
  input  logic                baOut,
  input  word_t               bus,
  output word_t [NumRegs-1:0] regWords
);

  word_t [NumRegs-1:0] regs;

  always_ff @(posedge clock) begin
    if (rst) begin
      regs <= '0;
    end else begin
      for (int i = 0; i < NumRegs; i++) begin
        if (regIn[i]) regs[i] <= bus;
      end
    end
  end

  always_comb begin
    regWords = regs;
    if (baOut) regWords[0] = '0;   // R0 as base reads zero
  end

endmodule

// ==== common/cpuPkg.sv ====
package cpuPkg;

  localparam int ShiftBits = 5;
  localparam int NumRegs = 16;

  // instruction field positions
  localparam int OpMsb = 31;
  localparam int OpLsb = 27;
  localparam int RaMsb = 26;
  localparam int RaLsb = 23;
  localparam int RbMsb = 22;
  localparam int RbLsb = 19;
  localparam int RcMsb = 18;
  localparam int RcLsb = 15;
  localparam int ImmMsb = 18;
  localparam int ImmLsb = 0;
  localparam int ImmBits = ImmMsb - ImmLsb + 1;

  typedef logic [31:0] word_t;
  typedef logic [63:0] dword_t;
  typedef logic [3:0] regIdx_t;
  typedef logic [NumRegs-1:0] regMask_t;

  typedef enum logic [4:0] {
    opAdd = 5'd0,
    opSub = 5'd1,
    opAnd = 5'd2,
    opOr = 5'd3,
    opShl = 5'd4,
    opShr = 5'd5,
    opNeg = 5'd6,
    opNot = 5'd7,
    opAddi = 5'd8,
    opMul = 5'd9,
    opMfhi = 5'd10,
    opMflo = 5'd11,
    opIn = 5'd12,
    opOut = 5'd13
  } opcode_t;

  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOr = 4'd3,
    aluShl = 4'd4,
    aluShr = 4'd5,
    aluNeg = 4'd6,
    aluNot = 4'd7,
    aluMul = 4'd8
  } aluOp_t;

  typedef struct packed {
    regMask_t regIn;
    regMask_t regOut;
    logic baOut;        // R0 reads as zero
    logic hiIn;
    logic loIn;
    logic hiOut;
    logic loOut;
    logic yIn;
    logic zIn;
    logic zHighOut;
    logic zLowOut;
    logic cOut;         // immediate onto bus
    logic inPortOut;
    logic outPortEn;
    aluOp_t aluOp;
  } ctrl_t;

endpackage
